//--- src/vertex_settings.svh
`ifndef VERTEX_SETTINGS_SVH
`define VERTEX_SETTINGS_SVH

// datapath widths
`define VERTEX_BITS 32
`define ADDR_BITS 32

// cacheline geometry
`define CACHELINE_VERTEX_NUM 4
`define CACHELINE_BYTES 16
`define LINE_BITS 128

// one stream per vertex array
`define VERTEX_ARRAYS 6

// job queue, two batches deep
`define JOB_FIFO_DEPTH 8
`define JOB_FIFO_ALFULL_FREE 4 // room for one whole batch

`endif

//--- src/vertex_pkg.sv
`default_nettype none
`include "vertex_settings.svh"

package vertex_pkg;

	// issue order of the six reads in a batch
	typedef enum logic [2:0] {
		IN_DEGREE,
		OUT_DEGREE,
		EDGES_IDX,
		INV_IN_DEGREE,
		INV_OUT_DEGREE,
		INV_EDGES_IDX
	} vertex_array_e;

	typedef struct packed {
		logic                   valid;
		vertex_array_e          array;
		logic [`ADDR_BITS-1:0]  address;
		logic [2:0]             count; // vertices in this batch
	} read_cmd_t;

	// value k of the line sits at bits k*32 upward
	typedef struct packed {
		logic                   valid;
		vertex_array_e          array;
		logic [`LINE_BITS-1:0]  data;
	} read_beat_t;

	typedef struct packed {
		logic                    valid;
		logic [`VERTEX_BITS-1:0] num_vertices;
		logic [`ADDR_BITS-1:0]   in_degree;
		logic [`ADDR_BITS-1:0]   out_degree;
		logic [`ADDR_BITS-1:0]   edges_idx;
		logic [`ADDR_BITS-1:0]   inv_in_degree;
		logic [`ADDR_BITS-1:0]   inv_out_degree;
		logic [`ADDR_BITS-1:0]   inv_edges_idx;
	} vertex_job_t;

	typedef struct packed {
		logic                    valid;
		logic [`VERTEX_BITS-1:0] id;
		logic [`VERTEX_BITS-1:0] in_degree;
		logic [`VERTEX_BITS-1:0] out_degree;
		logic [`VERTEX_BITS-1:0] edges_idx;
		logic [`VERTEX_BITS-1:0] inv_in_degree;
		logic [`VERTEX_BITS-1:0] inv_out_degree;
		logic [`VERTEX_BITS-1:0] inv_edges_idx;
	} vertex_rec_t;

endpackage

`default_nettype wire

//--- src/vertex_read_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_read_sequencer (
	input  logic                     clock,
	input  logic                     rstn,
	input  vertex_pkg::vertex_job_t  job,
	input  logic                     cmd_alfull,
	input  logic                     beat_valid,
	input  logic [`VERTEX_ARRAYS-1:0] stream_pending,
	input  logic                     job_alfull,
	output vertex_pkg::read_cmd_t    rd_cmd,
	output logic                     shift_start,
	output logic [2:0]               line_count,
	output logic                     busy
);

	typedef enum logic [2:0] {S_IDLE, S_WAIT, S_SIZE, S_ISSUE, S_DONE} state_t;

	state_t state, next_state;
	vertex_pkg::vertex_job_t job_q;
	vertex_pkg::vertex_array_e issue_sel;
	logic [`VERTEX_BITS-1:0] remaining;
	logic [`ADDR_BITS-1:0] offset; // batch index times line size
	logic [2:0] outstanding;
	logic [2:0] batch_count;
	logic [`ADDR_BITS-1:0] base;
	logic any_pending;
	logic batch_ready;
	logic job_end;

	assign any_pending = |stream_pending;
	assign batch_ready = (remaining != '0) && (outstanding == '0) && !any_pending && !job_alfull;
	assign job_end = (remaining == '0) && (outstanding == '0) && !any_pending;
	assign batch_count = (remaining >= `CACHELINE_VERTEX_NUM) ?
		3'(`CACHELINE_VERTEX_NUM) : remaining[2:0];

	assign busy = (state != S_IDLE);
	// only in wait, so a beat back early mid-issue cannot start a lone stream
	assign shift_start = (state == S_WAIT) && (outstanding == '0) && any_pending;

	//////////////////////////////
	// state machine
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:  if (job.valid) next_state = S_WAIT;
			S_WAIT: begin
				if (batch_ready)
					next_state = S_SIZE;
				else if (job_end)
					next_state = S_DONE;
			end
			S_SIZE:  next_state = S_ISSUE;
			S_ISSUE: begin
				if (!cmd_alfull && issue_sel == vertex_pkg::INV_EDGES_IDX)
					next_state = S_WAIT; // last array of the batch
			end
			S_DONE:  next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (state == S_IDLE && job.valid)
			job_q <= job;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining  <= '0;
			offset     <= '0;
			line_count <= '0;
			issue_sel  <= vertex_pkg::IN_DEGREE;
		end else begin
			case (state)
				S_IDLE: begin
					if (job.valid) begin
						remaining <= job.num_vertices;
						offset    <= '0;
					end
				end
				S_SIZE: begin
					line_count <= batch_count;
					remaining  <= remaining - `VERTEX_BITS'(batch_count);
					issue_sel  <= vertex_pkg::IN_DEGREE;
				end
				S_ISSUE: begin
					if (rd_cmd.valid) begin
						if (issue_sel == vertex_pkg::INV_EDGES_IDX)
							offset <= offset + `CACHELINE_BYTES; // next batch
						else
							issue_sel <= vertex_pkg::vertex_array_e'(issue_sel + 3'd1);
					end
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// command out
	//////////////////////////////
	always_comb begin
		case (issue_sel)
			vertex_pkg::IN_DEGREE:      base = job_q.in_degree;
			vertex_pkg::OUT_DEGREE:     base = job_q.out_degree;
			vertex_pkg::EDGES_IDX:      base = job_q.edges_idx;
			vertex_pkg::INV_IN_DEGREE:  base = job_q.inv_in_degree;
			vertex_pkg::INV_OUT_DEGREE: base = job_q.inv_out_degree;
			default:                    base = job_q.inv_edges_idx;
		endcase
	end

	always_comb begin
		rd_cmd.valid   = (state == S_ISSUE) && !cmd_alfull;
		rd_cmd.array   = issue_sel;
		rd_cmd.address = base + offset;
		rd_cmd.count   = line_count;
	end

	// reads in flight, up on a command and down on a beat
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else if (rd_cmd.valid && !beat_valid)
			outstanding <= outstanding + 3'd1;
		else if (!rd_cmd.valid && beat_valid)
			outstanding <= outstanding - 3'd1;
	end

endmodule

`default_nettype wire

//--- src/cacheline_stream.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module cacheline_stream #(
	parameter vertex_pkg::vertex_array_e ARRAY = vertex_pkg::IN_DEGREE
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  vertex_pkg::read_beat_t  rd_beat,
	input  logic                    shift_start,
	input  logic [2:0]              line_count,
	output logic [`VERTEX_BITS-1:0] value,
	output logic                    value_valid,
	output logic                    pending
);

	logic [`LINE_BITS-1:0] line;
	logic [2:0] shifted; // values already sent from this line
	logic capture;

	assign capture = rd_beat.valid && (rd_beat.array == ARRAY);

	// low word is always the next vertex
	assign value = line[`VERTEX_BITS-1:0];
	assign value_valid = pending && shift_start;

	always_ff @(posedge clock) begin
		if (capture)
			line <= rd_beat.data;
		else if (value_valid)
			line <= line >> `VERTEX_BITS;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
			shifted <= '0;
		end else if (capture) begin
			pending <= 1'b1;
			shifted <= '0;
		end else if (value_valid) begin
			if (shifted + 3'd1 == line_count) begin
				pending <= 1'b0; // short last batch stops early
				shifted <= '0;
			end else begin
				shifted <= shifted + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/vertex_assembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_assembler (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic [`VERTEX_ARRAYS-1:0][`VERTEX_BITS-1:0] values,
	input  logic [`VERTEX_ARRAYS-1:0]                   values_valid,
	output vertex_pkg::vertex_rec_t                     rec,
	output logic                                        push,
	output logic [`VERTEX_BITS-1:0]                     pushed_count,
	output logic [`VERTEX_BITS-1:0]                     filtered_count
);

	vertex_pkg::vertex_rec_t rec_q;
	logic rec_valid;
	logic [`VERTEX_BITS-1:0] next_id; // runs across jobs
	logic all_valid;
	logic filter;

	assign all_valid = &values_valid;

	always_ff @(posedge clock) begin
		if (all_valid)
			rec_q <= {1'b1, next_id, values[0], values[1], values[2],
				values[3], values[4], values[5]};
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rec_valid <= 1'b0;
			next_id   <= '0;
		end else begin
			rec_valid <= all_valid;
			if (all_valid)
				next_id <= next_id + 1'b1;
		end
	end

	always_comb begin
		rec = rec_q;
		rec.valid = rec_valid;
	end

	// no inverse out-degree, nothing to schedule
	assign push   = rec_valid && (rec_q.inv_out_degree != '0);
	assign filter = rec_valid && (rec_q.inv_out_degree == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pushed_count   <= '0;
			filtered_count <= '0;
		end else begin
			if (push)
				pushed_count <= pushed_count + 1'b1;
			if (filter)
				filtered_count <= filtered_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/vertex_job_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_job_fifo #(
	parameter int DEPTH       = `JOB_FIFO_DEPTH,
	parameter int ALFULL_FREE = `JOB_FIFO_ALFULL_FREE
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    push,
	input  vertex_pkg::vertex_rec_t rec,
	input  logic                    pop,
	output vertex_pkg::vertex_rec_t head,
	output logic                    alfull
);

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	vertex_pkg::vertex_rec_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic do_push, do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop  = pop && (count != '0); // empty pop ignored
	assign do_push = push && (count != CNT_BITS'(DEPTH));

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= rec;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (!do_push && do_pop)
				count <= count - 1'b1;
		end
	end

	always_comb begin
		head = mem[rd_ptr];
		head.valid = (count != '0);
	end

	// counts a push in flight too, the record leaving the assembler now
	assign alfull = (int'(count) + int'(push)) > (DEPTH - ALFULL_FREE);

endmodule

`default_nettype wire

//--- src/vertex_job_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_job_control (
	input  logic                    clock,
	input  logic                    rstn,
	input  vertex_pkg::vertex_job_t job,
	input  logic                    cmd_alfull,
	input  vertex_pkg::read_beat_t  rd_beat,
	input  logic                    vertex_pop,
	output vertex_pkg::read_cmd_t   rd_cmd,
	output vertex_pkg::vertex_rec_t vertex_out,
	output logic                    busy,
	output logic [`VERTEX_BITS-1:0] pushed_count,
	output logic [`VERTEX_BITS-1:0] filtered_count
);

	logic shift_start;
	logic [2:0] line_count;
	logic [`VERTEX_ARRAYS-1:0] stream_pending;
	logic [`VERTEX_ARRAYS-1:0] values_valid;
	logic [`VERTEX_ARRAYS-1:0][`VERTEX_BITS-1:0] values;
	logic job_alfull;
	logic push;
	vertex_pkg::vertex_rec_t rec;

	//////////////////////////////
	// read commands
	//////////////////////////////
	vertex_read_sequencer sequencer_i (
		.clock          (clock),
		.rstn           (rstn),
		.job            (job),
		.cmd_alfull     (cmd_alfull),
		.beat_valid     (rd_beat.valid),
		.stream_pending (stream_pending),
		.job_alfull     (job_alfull),
		.rd_cmd         (rd_cmd),
		.shift_start    (shift_start),
		.line_count     (line_count),
		.busy           (busy)
	);

	// one stream per array, index follows the enum
	for (genvar i = 0; i < `VERTEX_ARRAYS; i++) begin : g_stream
		cacheline_stream #(
			.ARRAY(vertex_pkg::vertex_array_e'(i))
		) stream_i (
			.clock       (clock),
			.rstn        (rstn),
			.rd_beat     (rd_beat),
			.shift_start (shift_start),
			.line_count  (line_count),
			.value       (values[i]),
			.value_valid (values_valid[i]),
			.pending     (stream_pending[i])
		);
	end

	//////////////////////////////
	// records and job queue
	//////////////////////////////
	vertex_assembler assembler_i (
		.clock          (clock),
		.rstn           (rstn),
		.values         (values),
		.values_valid   (values_valid),
		.rec            (rec),
		.push           (push),
		.pushed_count   (pushed_count),
		.filtered_count (filtered_count)
	);

	vertex_job_fifo #(
		.DEPTH       (`JOB_FIFO_DEPTH),
		.ALFULL_FREE (`JOB_FIFO_ALFULL_FREE)
	) job_fifo_i (
		.clock  (clock),
		.rstn   (rstn),
		.push   (push),
		.rec    (rec),
		.pop    (vertex_pop),
		.head   (vertex_out),
		.alfull (job_alfull)
	);

endmodule

`default_nettype wire

//--- verification/vertex_job_control_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_job_control_props #(
	parameter int DEPTH = `JOB_FIFO_DEPTH
) (
	input logic                         clock,
	input logic                         rstn,
	input logic                         cmd_alfull,
	input logic                         cmd_valid,
	input logic                         fifo_push,
	input logic [$clog2(DEPTH+1)-1:0]   fifo_count,
	input logic                         out_valid
);

	// memory stall holds the command in the same cycle
	cmd_held: assert property (@(posedge clock) disable iff (!rstn)
		cmd_alfull |-> !cmd_valid)
		else $error("read command issued while cmd_alfull was high");

	push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		(fifo_count == DEPTH) |-> !fifo_push)
		else $error("job queue pushed while full");

	out_empty_after_reset: assert property (@(posedge clock)
		$rose(rstn) |-> !out_valid)
		else $error("vertex_out valid right after reset");

endmodule

bind vertex_job_control vertex_job_control_props #(.DEPTH(`JOB_FIFO_DEPTH)) props_i (
	.clock      (clock),
	.rstn       (rstn),
	.cmd_alfull (cmd_alfull),
	.cmd_valid  (rd_cmd.valid),
	.fifo_push  (push),
	.fifo_count (job_fifo_i.count),
	.out_valid  (vertex_out.valid)
);

`default_nettype wire

//--- verification/vertex_job_control_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "vertex_settings.svh"

module vertex_job_control_tb;

	localparam int NUM_ROWS = 6;
	localparam logic [31:0] SEED = 32'hc64b6f1e;

	// one job per row, first_id is the id expected for vertex 0
	typedef struct packed {
		logic [31:0]      num;
		logic [31:0]      first_id;
		logic [0:5][31:0] bases; // enum order
		logic [7:0]       stall_pct;
		logic [7:0]       delay_min;
		logic [7:0]       delay_max;
		logic [7:0]       pop_pct;
	} job_row_t;

	logic clock;
	logic rstn;
	vertex_pkg::vertex_job_t job;
	logic cmd_alfull;
	vertex_pkg::read_beat_t rd_beat;
	logic vertex_pop;
	vertex_pkg::read_cmd_t rd_cmd;
	vertex_pkg::vertex_rec_t vertex_out;
	logic busy;
	logic [`VERTEX_BITS-1:0] pushed_count;
	logic [`VERTEX_BITS-1:0] filtered_count;

	job_row_t rows [NUM_ROWS];
	string row_name [NUM_ROWS];
	bit table_loaded;
	int cur; // row in progress
	int cycle;
	int errors;
	int checks;
	logic [31:0] rng;
	int cmd_batch;
	int cmd_idx;
	int exp_v [$]; // vertex indices still to be popped
	int exp_pushed;
	int exp_filtered;
	logic [31:0] resp_addr [$];
	int resp_arr [$];
	int resp_due [$];

	vertex_job_control dut_i (
		.clock          (clock),
		.rstn           (rstn),
		.job            (job),
		.cmd_alfull     (cmd_alfull),
		.rd_beat        (rd_beat),
		.vertex_pop     (vertex_pop),
		.rd_cmd         (rd_cmd),
		.vertex_out     (vertex_out),
		.busy           (busy),
		.pushed_count   (pushed_count),
		.filtered_count (filtered_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////
	// memory rule and random draws
	//////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw(input int n);
		rng = xorshift(rng);
		return int'(rng % n);
	endfunction

	function automatic logic [31:0] mem_value(input int a, input logic [31:0] addr);
		logic [31:0] x;
		x = xorshift(addr ^ SEED);
		if (a == int'(vertex_pkg::INV_OUT_DEGREE) && x[1:0] == 2'b00)
			x = '0; // about one vertex in four gets filtered
		return x;
	endfunction

	function automatic logic [31:0] rec_value(input vertex_pkg::vertex_rec_t r, input int a);
		case (a)
			0:       return r.in_degree;
			1:       return r.out_degree;
			2:       return r.edges_idx;
			3:       return r.inv_in_degree;
			4:       return r.inv_out_degree;
			default: return r.inv_edges_idx;
		endcase
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("ERR %s %s expected %h actual %h", row_name[cur], what, exp, act);
	endtask

	task automatic failure(input string msg);
		errors++;
		$display("%s: %s", row_name[cur], msg);
	endtask

	task automatic load_table();
		row_name[0] = "four_vertices";
		rows[0] = '{32'd4, 32'd0, '{32'h1000, 32'h1100, 32'h1200, 32'h1300, 32'h1400,
			32'h1500}, 8'd0, 8'd1, 8'd1, 8'd100};
		row_name[1] = "seven_with_stalls";
		rows[1] = '{32'd7, 32'd4, '{32'h2000, 32'h2200, 32'h2400, 32'h2600, 32'h2800,
			32'h2a00}, 8'd30, 8'd1, 8'd6, 8'd80};
		row_name[2] = "single_vertex";
		rows[2] = '{32'd1, 32'd11, '{32'h3040, 32'h3140, 32'h3240, 32'h3340, 32'h3440,
			32'h3540}, 8'd0, 8'd1, 8'd3, 8'd100};
		row_name[3] = "ten_slow_pop";
		rows[3] = '{32'd10, 32'd12, '{32'h8000, 32'h8100, 32'h8200, 32'h8300, 32'h8400,
			32'h8500}, 8'd50, 8'd1, 8'd6, 8'd20};
		row_name[4] = "empty_job";
		rows[4] = '{32'd0, 32'd22, '{32'h9000, 32'h9100, 32'h9200, 32'h9300, 32'h9400,
			32'h9500}, 8'd0, 8'd1, 8'd1, 8'd100};
		row_name[5] = "after_empty";
		rows[5] = '{32'd5, 32'd22, '{32'ha010, 32'ha110, 32'ha210, 32'ha310, 32'ha410,
			32'ha510}, 8'd20, 8'd2, 8'd6, 8'd50};
		table_loaded = 1'b1;
	endtask

	//////////////////////////////
	// per cycle drive and checks
	//////////////////////////////
	task automatic drive_beat();
		logic [`LINE_BITS-1:0] data;
		rd_beat = '0;
		for (int i = 0; i < resp_due.size(); i++) begin
			if (resp_due[i] <= cycle) begin
				for (int k = 0; k < `CACHELINE_VERTEX_NUM; k++)
					data[k*32 +: 32] = mem_value(resp_arr[i], resp_addr[i] + 32'(4 * k));
				rd_beat.valid = 1'b1;
				rd_beat.array = vertex_pkg::vertex_array_e'(resp_arr[i]);
				rd_beat.data  = data;
				resp_addr.delete(i);
				resp_arr.delete(i);
				resp_due.delete(i);
				break;
			end
		end
	endtask

	task automatic check_command();
		int rem;
		int exp_count;
		logic [31:0] exp_addr;
		if (!rd_cmd.valid)
			return;
		rem = int'(rows[cur].num) - `CACHELINE_VERTEX_NUM * cmd_batch;
		if (rem <= 0) begin
			failure("read command issued with no vertices left");
			return;
		end
		exp_count = (rem < `CACHELINE_VERTEX_NUM) ? rem : `CACHELINE_VERTEX_NUM;
		exp_addr = rows[cur].bases[cmd_idx] + 32'(`CACHELINE_BYTES * cmd_batch);
		checks++;
		if (int'(rd_cmd.array) != cmd_idx)
			mismatch("cmd_array", 32'(cmd_idx), 32'(rd_cmd.array));
		if (rd_cmd.address !== exp_addr)
			mismatch("cmd_address", exp_addr, rd_cmd.address);
		if (int'(rd_cmd.count) != exp_count)
			mismatch("cmd_count", 32'(exp_count), 32'(rd_cmd.count));
		// memory answers what was asked, after a random delay
		resp_addr.push_back(rd_cmd.address);
		resp_arr.push_back(int'(rd_cmd.array));
		resp_due.push_back(cycle + int'(rows[cur].delay_min)
			+ draw(int'(rows[cur].delay_max) - int'(rows[cur].delay_min) + 1));
		cmd_idx++;
		if (cmd_idx == 6) begin
			cmd_idx = 0;
			cmd_batch++;
		end
	endtask

	task automatic check_pop();
		int v;
		if (vertex_out.valid && vertex_out.inv_out_degree == '0)
			failure("vertex with zero inverse out-degree reached the job queue");
		if (!(vertex_pop && vertex_out.valid))
			return;
		if (exp_v.size() == 0) begin
			failure("record popped that was not expected");
			return;
		end
		v = exp_v.pop_front();
		checks++;
		if (vertex_out.id !== rows[cur].first_id + 32'(v))
			mismatch("rec_id", rows[cur].first_id + 32'(v), vertex_out.id);
		for (int a = 0; a < 6; a++) begin
			if (rec_value(vertex_out, a) !== mem_value(a, rows[cur].bases[a] + 32'(4 * v)))
				mismatch("rec_value", mem_value(a, rows[cur].bases[a] + 32'(4 * v)),
					rec_value(vertex_out, a));
		end
	endtask

	task automatic tick(input bit start);
		@(negedge clock);
		cycle++;
		job.valid          = start;
		job.num_vertices   = rows[cur].num;
		job.in_degree      = rows[cur].bases[0];
		job.out_degree     = rows[cur].bases[1];
		job.edges_idx      = rows[cur].bases[2];
		job.inv_in_degree  = rows[cur].bases[3];
		job.inv_out_degree = rows[cur].bases[4];
		job.inv_edges_idx  = rows[cur].bases[5];
		cmd_alfull = (draw(100) < int'(rows[cur].stall_pct));
		drive_beat();
		vertex_pop = (draw(100) < int'(rows[cur].pop_pct));
		#1; // outputs settled until the next rising edge
		check_command();
		check_pop();
	endtask

	task automatic run_row(input int r);
		cur = r;
		cmd_batch = 0;
		cmd_idx = 0;
		for (int v = 0; v < int'(rows[r].num); v++) begin
			if (mem_value(4, rows[r].bases[4] + 32'(4 * v)) != '0) begin
				exp_v.push_back(v);
				exp_pushed++;
			end else begin
				exp_filtered++;
			end
		end
		tick(1'b1);
		tick(1'b0);
		if (!busy)
			failure("busy did not rise after the job pulse");
		while (busy)
			tick(1'b0);
		while (exp_v.size() != 0 || vertex_out.valid)
			tick(1'b0); // drain the queue
		repeat (2) tick(1'b0);
		if (busy)
			failure("busy high again after the job ended");
		if (pushed_count !== 32'(exp_pushed))
			mismatch("pushed_count", 32'(exp_pushed), pushed_count);
		if (filtered_count !== 32'(exp_filtered))
			mismatch("filtered_count", 32'(exp_filtered), filtered_count);
		if (cmd_batch != (int'(rows[r].num) + 3) / 4 || cmd_idx != 0)
			mismatch("cmd_batches", 32'((int'(rows[r].num) + 3) / 4), 32'(cmd_batch));
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		rstn = 1'b0;
		job = '0;
		cmd_alfull = 1'b0;
		rd_beat = '0;
		vertex_pop = 1'b0;
		rng = SEED;
		cycle = 0;
		errors = 0;
		checks = 0;
		exp_pushed = 0;
		exp_filtered = 0;
		cur = 0;
		load_table();
		repeat (2) @(negedge clock);
		if (busy || rd_cmd.valid || vertex_out.valid || pushed_count != '0
			|| filtered_count != '0)
			failure("outputs not cleared during reset");
		rstn = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// limit grows with the vertices in the table
	initial begin
		int limit;
		wait (table_loaded);
		limit = 1000;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += int'(rows[r].num) * 200;
		repeat (limit) @(posedge clock);
		$display("watchdog timeout after %0d cycles, a job never finished", limit);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/vertex_pkg.sv
src/vertex_read_sequencer.sv
src/cacheline_stream.sv
src/vertex_assembler.sv
src/vertex_job_fifo.sv
src/vertex_job_control.sv
verification/vertex_job_control_props.sv
verification/vertex_job_control_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= vertex_job_control_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD_DIR)
